// File: src/rtc_pkg.sv
/* Time steps are exact only when CLK_FREQ_HZ divides 10^9 evenly.
   Channel count and log depth are fixed here for the whole design. */

`default_nettype none

package rtc_pkg;

    // ========================================================================
    // Clock and time step
    // ========================================================================

    // 4 ns clock
    localparam int unsigned CLK_FREQ_HZ = 250_000_000;

    // Nanoseconds added on every edge
    localparam int unsigned NSEC_INC = 1_000_000_000 / CLK_FREQ_HZ;

    // Last nsec value before the second rolls over
    localparam int unsigned NSEC_MAX = 1_000_000_000 - NSEC_INC;

    // ========================================================================
    // Event channels and stamp log
    // ========================================================================

    localparam int NUM_CHAN  = 2;
    localparam int CHAN_W    = 1;
    localparam int LOG_DEPTH = 16;
    localparam int LOG_AW    = 4;

    // ========================================================================
    // Types
    // ========================================================================

    // Seconds in the upper word, nanoseconds in the lower
    typedef struct packed {
        logic [31:0] sec;
        logic [31:0] nsec;
    } rtc_time_t;

    // One log entry, source channel plus captured time
    typedef struct packed {
        logic [CHAN_W-1:0] chan;
        rtc_time_t         tm;
    } stamp_t;

    // Set strobe travels with the value it loads
    typedef struct packed {
        logic      load;
        rtc_time_t tm;
    } time_set_t;

endpackage

`default_nettype wire

// File: src/rtc_core.sv
/* Out-of-range nsec loaded by a set rolls over on the following edge.
   The seconds counter wraps silently after 2^32 seconds. */

`timescale 1ns/100ps
`default_nettype none

module rtc_core (
    input  var logic                clk,
    input  var logic                rst,
    input  var rtc_pkg::time_set_t  set,
    input  var logic                snap,
    output var rtc_pkg::rtc_time_t  now,
    output var rtc_pkg::rtc_time_t  snap_time,
    output var logic                pps
);

    import rtc_pkg::*;

    // ========================================================================
    // Time counter
    // ========================================================================

    logic rollover;

    // Last step of the current second
    // >= also catches a bad nsec written by software
    assign rollover = (now.nsec >= NSEC_MAX);

    always_ff @(posedge clk) begin
        if (rst) begin
            now <= '0;
        end else if (set.load) begin
            // Software load wins over counting
            now <= set.tm;
        end else if (rollover) begin
            now.sec  <= now.sec + 32'd1;
            now.nsec <= '0;
        end else begin
            now.nsec <= now.nsec + 32'(NSEC_INC);
        end
    end

    // ========================================================================
    // Internal PPS
    // ========================================================================

    // High while now shows nsec 0 after a real rollover
    // A set on the rollover edge suppresses the pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            pps <= 1'b0;
        end else begin
            pps <= rollover && !set.load;
        end
    end

    // ========================================================================
    // Snapshot readout
    // ========================================================================

    // Frozen copy for software, held between snap strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            snap_time <= '0;
        end else if (snap) begin
            snap_time <= now;
        end
    end

endmodule

`default_nettype wire

// File: src/event_stamp.sv
/* The pin is asynchronous; pulses shorter than two clocks may be missed.
   Only one stamp is held; edges arriving while it waits are counted in miss. */

`timescale 1ns/100ps
`default_nettype none

module event_stamp #(
    parameter int CHAN = 0
) (
    input  var logic                clk,
    input  var logic                rst,
    input  var logic                pin,
    input  var rtc_pkg::rtc_time_t  now,
    input  var logic                grant,
    output var logic                req,
    output var rtc_pkg::stamp_t     stamp,
    output var logic [7:0]          miss
);

    import rtc_pkg::*;

    logic      pin_s0;
    logic      pin_s1;
    logic      pin_q;
    logic      rise;
    logic      take;
    logic      live;
    rtc_time_t held;

    // Two-flop synchronizer, then the edge register
    always_ff @(posedge clk) begin
        if (rst) begin
            pin_s0 <= 1'b0;
            pin_s1 <= 1'b0;
            pin_q  <= 1'b0;
        end else begin
            pin_s0 <= pin;
            pin_s1 <= pin_s0;
            pin_q  <= pin_s1;
        end
    end

    assign rise = pin_s1 & ~pin_q;

    // New stamp accepted when idle, or when the old one leaves this cycle
    assign take = rise & (~req | grant);

    always_ff @(posedge clk) begin
        if (rst) begin
            req  <= 1'b0;
            live <= 1'b0;
            miss <= '0;
        end else begin
            live <= take;
            if (take) begin
                req <= 1'b1;
            end else if (grant) begin
                req <= 1'b0;
            end
            // Edge lost behind a pending stamp
            if (rise && req && !grant) begin
                miss <= miss + 8'd1;
            end
        end
    end

    // First pending cycle passes now straight through,
    // the register then keeps that same value until grant
    always_ff @(posedge clk) begin
        if (live) begin
            held <= now;
        end
    end

    assign stamp.chan = CHAN_W'(CHAN);
    assign stamp.tm   = live ? now : held;

endmodule

`default_nettype wire

// File: src/stamp_arbiter.sv
/* Grant is combinational from req; one write per cycle at most.
   The log never pushes back, so a granted stamp is always written. */

`timescale 1ns/100ps
`default_nettype none

module stamp_arbiter (
    input  var logic                          clk,
    input  var logic                          rst,
    input  var logic [rtc_pkg::NUM_CHAN-1:0]  req,
    input  var rtc_pkg::stamp_t               stamp [rtc_pkg::NUM_CHAN],
    output var logic [rtc_pkg::NUM_CHAN-1:0]  grant,
    output var logic                          wr,
    output var rtc_pkg::stamp_t               wr_stamp
);

    import rtc_pkg::*;

    logic [CHAN_W-1:0] last;
    logic [CHAN_W-1:0] win;

    // Search starts one past the last winner
    always_comb begin
        int idx;
        grant    = '0;
        wr       = 1'b0;
        win      = last;
        for (int i = 0; i < NUM_CHAN; i++) begin
            idx = (int'(last) + 1 + i) % NUM_CHAN;
            if (!wr && req[idx]) begin
                wr  = 1'b1;
                win = CHAN_W'(idx);
            end
        end
        if (wr) begin
            grant[win] = 1'b1;
        end
        wr_stamp = stamp[win];
    end

    // Reset to the top index so channel 0 wins first
    always_ff @(posedge clk) begin
        if (rst) begin
            last <= CHAN_W'(NUM_CHAN - 1);
        end else if (wr) begin
            last <= win;
        end
    end

endmodule

`default_nettype wire

// File: src/stamp_log.sv
/* Head is fall-through and valid whenever the log holds an entry.
   Writes into a full log are lost and only counted; pop when empty is ignored. */

`timescale 1ns/100ps
`default_nettype none

module stamp_log (
    input  var logic             clk,
    input  var logic             rst,
    input  var logic             wr,
    input  var rtc_pkg::stamp_t  wr_stamp,
    input  var logic             pop,
    output var logic             valid,
    output var rtc_pkg::stamp_t  head,
    output var logic [15:0]      dropped
);

    import rtc_pkg::*;

    // ========================================================================
    // Storage and pointers
    // ========================================================================

    stamp_t            mem [LOG_DEPTH];
    logic [LOG_AW-1:0] wptr;
    logic [LOG_AW-1:0] rptr;
    logic [LOG_AW:0]   count;
    logic              full;
    logic              do_wr;
    logic              do_pop;

    assign full   = (count == (LOG_AW+1)'(LOG_DEPTH));
    assign valid  = (count != '0);
    assign do_wr  = wr & ~full;
    assign do_pop = pop & valid;

    // Entry memory, no reset
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wptr] <= wr_stamp;
        end
    end

    // Pointers wrap naturally at LOG_DEPTH
    always_ff @(posedge clk) begin
        if (rst) begin
            wptr    <= '0;
            rptr    <= '0;
            count   <= '0;
            dropped <= '0;
        end else begin
            if (do_wr) begin
                wptr <= wptr + 1'b1;
            end
            if (do_pop) begin
                rptr <= rptr + 1'b1;
            end
            case ({do_wr, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Overflow tally
            if (wr && full) begin
                dropped <= dropped + 16'd1;
            end
        end
    end

    // ========================================================================
    // Fall-through head
    // ========================================================================

    assign head = mem[rptr];

endmodule

`default_nettype wire

// File: src/rtc_timestamp_top.sv
/* Event pins are asynchronous and synchronized inside each channel.
   Losses show only in miss and log_dropped; nothing stalls. */

`timescale 1ns/100ps
`default_nettype none

module rtc_timestamp_top (
    input  var logic                          clk,
    input  var logic                          rst,
    input  var rtc_pkg::time_set_t            set,
    input  var logic                          snap,
    input  var logic [rtc_pkg::NUM_CHAN-1:0]  pins,
    input  var logic                          pop,
    output var rtc_pkg::rtc_time_t            rtc_time,
    output var rtc_pkg::rtc_time_t            snap_time,
    output var logic                          pps,
    output var logic                          log_valid,
    output var rtc_pkg::stamp_t               log_head,
    output var logic [15:0]                   log_dropped,
    output var logic [7:0]                    miss [rtc_pkg::NUM_CHAN]
);

    import rtc_pkg::*;

    rtc_time_t           now;
    logic [NUM_CHAN-1:0] ch_req;
    logic [NUM_CHAN-1:0] ch_grant;
    stamp_t              ch_stamp [NUM_CHAN];
    logic                log_wr;
    stamp_t              log_wr_stamp;

    assign rtc_time = now;

    rtc_core rtc_core_inst (
        .clk       (clk),
        .rst       (rst),
        .set       (set),
        .snap      (snap),
        .now       (now),
        .snap_time (snap_time),
        .pps       (pps)
    );

    // One stamp channel per pin
    for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
        event_stamp #(
            .CHAN (i)
        ) event_stamp_inst (
            .clk   (clk),
            .rst   (rst),
            .pin   (pins[i]),
            .now   (now),
            .grant (ch_grant[i]),
            .req   (ch_req[i]),
            .stamp (ch_stamp[i]),
            .miss  (miss[i])
        );
    end

    stamp_arbiter stamp_arbiter_inst (
        .clk      (clk),
        .rst      (rst),
        .req      (ch_req),
        .stamp    (ch_stamp),
        .grant    (ch_grant),
        .wr       (log_wr),
        .wr_stamp (log_wr_stamp)
    );

    stamp_log stamp_log_inst (
        .clk      (clk),
        .rst      (rst),
        .wr       (log_wr),
        .wr_stamp (log_wr_stamp),
        .pop      (pop),
        .valid    (log_valid),
        .head     (log_head),
        .dropped  (log_dropped)
    );

endmodule

`default_nettype wire

// File: testbench/tb_rtc_timestamp.sv
/* Reference model advances on every edge and tracks channels, arbiter and log.
   All checks run on the falling edge while the DUT outputs are stable. */

`timescale 1ns/100ps
`default_nettype none

module tb_rtc_timestamp;

    import rtc_pkg::*;

    // One table step with strobes first, pins for hold cycles, then pops
    typedef struct packed {
        time_set_t           set;
        logic [NUM_CHAN-1:0] pins;
        int                  hold;
        logic                snap;
        int                  pops;
    } row_t;

    logic                clk;
    logic                rst;
    time_set_t           set;
    logic                snap;
    logic [NUM_CHAN-1:0] pins;
    logic                pop;
    rtc_time_t           rtc_time;
    rtc_time_t           snap_time;
    logic                pps;
    logic                log_valid;
    stamp_t              log_head;
    logic [15:0]         log_dropped;
    logic [7:0]          miss [NUM_CHAN];

    row_t rows [$];
    int   watch_cycles = 0;

    // Reference state
    rtc_time_t           m_time;
    rtc_time_t           m_snap;
    logic                m_pps;
    logic [NUM_CHAN-1:0] m_s0;
    logic [NUM_CHAN-1:0] m_s1;
    logic [NUM_CHAN-1:0] m_q;
    logic [NUM_CHAN-1:0] m_pend;
    rtc_time_t           m_ptime [NUM_CHAN];
    logic [7:0]          m_miss [NUM_CHAN];
    int                  m_last;
    stamp_t              m_log [$];
    logic [15:0]         m_dropped;

    rtc_timestamp_top rtc_timestamp_top_inst (
        .clk         (clk),
        .rst         (rst),
        .set         (set),
        .snap        (snap),
        .pins        (pins),
        .pop         (pop),
        .rtc_time    (rtc_time),
        .snap_time   (snap_time),
        .pps         (pps),
        .log_valid   (log_valid),
        .log_head    (log_head),
        .log_dropped (log_dropped),
        .miss        (miss)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic add_row(input logic load, input logic [31:0] sec, input logic [31:0] nsec,
                           input logic [NUM_CHAN-1:0] pat, input int hold, input logic snp,
                           input int pops);
        row_t r;
        r.set.load    = load;
        r.set.tm.sec  = sec;
        r.set.tm.nsec = nsec;
        r.pins        = pat;
        r.hold        = hold;
        r.snap        = snp;
        r.pops        = pops;
        rows.push_back(r);
    endtask

    task automatic compare_value(input string name, input logic [64:0] got,
                                 input logic [64:0] exp);
        assert (got === exp) else begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    // ========================================================================
    // Reference model sampling the inputs as they were before each edge
    // ========================================================================

    always @(posedge clk) begin
        rtc_time_t           nt;
        stamp_t              s;
        int                  gw;
        int                  idx;
        logic                full_old;
        logic                valid_old;
        logic [NUM_CHAN-1:0] rise;
        if (rst) begin
            m_time    = '0;
            m_snap    = '0;
            m_pps     = 1'b0;
            m_s0      = '0;
            m_s1      = '0;
            m_q       = '0;
            m_pend    = '0;
            m_last    = NUM_CHAN - 1;
            m_dropped = '0;
            m_log.delete();
            for (int c = 0; c < NUM_CHAN; c++) begin
                m_miss[c] = '0;
            end
        end else begin
            nt = m_time;
            if (set.load) begin
                nt = set.tm;
            end else if (m_time.nsec == NSEC_MAX) begin
                nt.sec  = m_time.sec + 32'd1;
                nt.nsec = '0;
            end else begin
                nt.nsec = m_time.nsec + NSEC_INC;
            end
            m_pps = !set.load && (m_time.nsec == NSEC_MAX);
            if (snap) begin
                m_snap = m_time;
            end
            rise = m_s1 & ~m_q;
            // Round robin from one past the last winner
            gw = -1;
            for (int i = 0; i < NUM_CHAN; i++) begin
                idx = (m_last + 1 + i) % NUM_CHAN;
                if (gw < 0 && m_pend[idx]) begin
                    gw = idx;
                end
            end
            full_old  = (m_log.size() == LOG_DEPTH);
            valid_old = (m_log.size() != 0);
            if (pop && valid_old) begin
                void'(m_log.pop_front());
            end
            if (gw >= 0) begin
                s.chan = CHAN_W'(gw);
                s.tm   = m_ptime[gw];
                if (full_old) begin
                    m_dropped = m_dropped + 16'd1;
                end else begin
                    m_log.push_back(s);
                end
                m_last = gw;
            end
            // Capture takes the time shown after this edge
            for (int c = 0; c < NUM_CHAN; c++) begin
                if (rise[c] && m_pend[c] && gw != c) begin
                    m_miss[c] = m_miss[c] + 8'd1;
                end
                if (rise[c] && (!m_pend[c] || gw == c)) begin
                    m_pend[c]  = 1'b1;
                    m_ptime[c] = nt;
                end else if (gw == c) begin
                    m_pend[c] = 1'b0;
                end
            end
            m_q    = m_s1;
            m_s1   = m_s0;
            m_s0   = pins;
            m_time = nt;
        end
    end

    // Compare every output once per cycle
    always @(negedge clk) begin
        if (!rst) begin
            compare_value("rtc_time", rtc_time, m_time);
            compare_value("pps", pps, m_pps);
            compare_value("snap_time", snap_time, m_snap);
            compare_value("log_valid", log_valid, m_log.size() != 0);
            if (m_log.size() != 0) begin
                compare_value("log_head", log_head, m_log[0]);
            end
            compare_value("log_dropped", log_dropped, m_dropped);
            for (int c = 0; c < NUM_CHAN; c++) begin
                compare_value($sformatf("miss[%0d]", c), miss[c], m_miss[c]);
            end
        end
    end

    // Watchdog
    initial begin
        wait (watch_cycles > 0);
        repeat (watch_cycles) @(posedge clk);
        $display("Timeout: the stimulus table did not finish in time");
        $display("Test failures found");
        $fatal(1);
    end

    // ========================================================================
    // Stimulus
    // ========================================================================

    initial begin
        row_t        r;
        int          n;
        int          gap;
        int          total;
        logic        ready;
        rst       = 1'b1;
        set       = '0;
        snap      = 1'b0;
        pins      = '0;
        pop       = 1'b0;
        void'($urandom(32'haf87));

        add_row(1'b1, 32'd100, 32'd0, 2'b00, 6, 1'b1, 0);
        add_row(1'b0, 32'd0, 32'd0, 2'b00, 5, 1'b1, 0);
        // Three steps short of the rollover
        add_row(1'b1, 32'd7, NSEC_MAX - 3 * NSEC_INC, 2'b00, 8, 1'b0, 0);
        // First pin activity since reset, both channels at once
        add_row(1'b0, 32'd0, 32'd0, 2'b11, 3, 1'b0, 2);
        add_row(1'b0, 32'd0, 32'd0, 2'b01, 3, 1'b0, 1);
        add_row(1'b0, 32'd0, 32'd0, 2'b10, 3, 1'b1, 1);
        add_row(1'b0, 32'd0, 32'd0, 2'b11, 3, 1'b0, 2);
        add_row(1'b0, 32'd0, 32'd0, 2'b11, 3, 1'b0, 2);
        add_row(1'b0, 32'd0, 32'd0, 2'b01, 3, 1'b0, 1);
        add_row(1'b0, 32'd0, 32'd0, 2'b11, 3, 1'b0, 2);
        // Fill past LOG_DEPTH without pops
        for (int i = 0; i < 10; i++) begin
            add_row(1'b0, 32'd0, 32'd0, 2'b11, 3, 1'b0, 0);
        end
        add_row(1'b0, 32'd0, 32'd0, 2'b00, 2, 1'b1, LOG_DEPTH);

        total = 8 + 64;
        foreach (rows[i]) begin
            total += 2 + rows[i].hold + 6 + 8 * rows[i].pops;
        end
        watch_cycles = total;

        repeat (8) @(posedge clk);
        rst <= 1'b0;

        foreach (rows[i]) begin
            r = rows[i];
            @(posedge clk);
            set  <= r.set;
            snap <= r.snap;
            pins <= r.pins;
            @(posedge clk);
            set.load <= 1'b0;
            snap     <= 1'b0;
            repeat (r.hold) @(posedge clk);
            pins <= '0;
            // One pop per pair of cycles while the log shows an entry
            n = r.pops;
            while (n > 0) begin
                @(negedge clk);
                ready = log_valid;
                @(posedge clk);
                pop <= ready;
                @(posedge clk);
                pop <= 1'b0;
                if (ready) begin
                    n--;
                end
            end
            gap = 3 + int'($urandom % 4);
            repeat (gap) @(posedge clk);
        end

        repeat (4) @(posedge clk);
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
src/rtc_pkg.sv
src/rtc_core.sv
src/event_stamp.sv
src/stamp_arbiter.sv
src/stamp_log.sv
src/rtc_timestamp_top.sv
testbench/tb_rtc_timestamp.sv

// File: run.sh
#!/bin/sh
# Compile with Verilator and run; the exit status is the simulator's
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_rtc_timestamp \
    -f list.f -o sim_tb \
    && ./obj_dir/sim_tb \
    || exit 1
